// ==== hw/rename_pkg.sv ====
// Rename stage package with widths, register-name types, instruction structs and operand union
package rename_pkg;

	// Register file sizes
	localparam int NUM_LREGS = 32;
	localparam int NUM_PREGS = 64;
	localparam int LREG_W = $clog2(NUM_LREGS);
	localparam int PREG_W = $clog2(NUM_PREGS);

	// Instructions per cycle and default retirement width
	localparam int ISSUE_WIDTH = 2;
	localparam int COMMIT_WIDTH_DEFAULT = 4;

	typedef logic [LREG_W-1:0] lreg_t;
	typedef logic [PREG_W-1:0] preg_t;

	// Register view of source 1, name sits in the low bits
	typedef struct packed {
		logic [31-PREG_W:0] pad;
		preg_t name;
	} src_reg_t;

	// Source 1 is either a full immediate or a register name
	typedef union packed {
		logic [31:0] imm;
		src_reg_t regv;
	} operand_u;

	// Decoded instruction from the previous stage
	typedef struct packed {
		logic valid;
		logic writeback;
		logic src1_imm;
		logic [4:0] cmd;
		lreg_t dest;
		lreg_t src0;
		operand_u src1;
	} dec_inst_t;

	// Instruction after renaming, sources hold physical names
	typedef struct packed {
		logic valid;
		logic writeback;
		logic src1_imm;
		logic [4:0] cmd;
		lreg_t dest;
		preg_t dest_preg;
		preg_t src0;
		operand_u src1;
	} ren_inst_t;

	// One map write, used for allocation and for commit
	typedef struct packed {
		logic valid;
		lreg_t lreg;
		preg_t preg;
	} map_wr_t;

endpackage

// ==== hw/map_table.sv ====
// Speculative and committed register maps with allocation, commit and restore
`timescale 1ns/1ps

module map_table #(
	parameter int COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH_DEFAULT
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic restart,
	input rename_pkg::map_wr_t alloc [rename_pkg::ISSUE_WIDTH],
	input rename_pkg::map_wr_t commit [COMMIT_WIDTH],
	input rename_pkg::lreg_t rd_lreg [2*rename_pkg::ISSUE_WIDTH],
	output rename_pkg::preg_t rd_preg [2*rename_pkg::ISSUE_WIDTH]
);
	import rename_pkg::*;

	// Current state of both maps
	preg_t spec_map [NUM_LREGS];
	preg_t comm_map [NUM_LREGS];

	// Values loaded at the next edge
	preg_t spec_next [NUM_LREGS];
	preg_t comm_next [NUM_LREGS];

	// Retirement updates, a later port overrides an earlier one
	always_comb begin
		comm_next = comm_map;
		for (int c = 0; c < COMMIT_WIDTH; c++) begin
			if (commit[c].valid) begin
				comm_next[commit[c].lreg] = commit[c].preg;
			end
		end
	end

	// Speculative map follows allocation unless a restart rolls it back
	always_comb begin
		if (restart) begin
			// Restore includes the commits of this same cycle
			spec_next = comm_next;
		end else begin
			spec_next = spec_map;
			// Slot 1 is younger and wins on the same lreg
			for (int s = 0; s < ISSUE_WIDTH; s++) begin
				if (alloc[s].valid) begin
					spec_next[alloc[s].lreg] = alloc[s].preg;
				end
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			// Identity mapping out of reset
			for (int i = 0; i < NUM_LREGS; i++) begin
				spec_map[i] <= preg_t'(i);
				comm_map[i] <= preg_t'(i);
			end
		end else begin
			spec_map <= spec_next;
			comm_map <= comm_next;
		end
	end

	// Source lookup on the map as it stands this cycle
	always_comb begin
		for (int r = 0; r < 2*ISSUE_WIDTH; r++) begin
			rd_preg[r] = spec_map[rd_lreg[r]];
		end
	end

endmodule

// ==== hw/operand_resolve.sv ====
// Source operand translation through the map and forwarding from slot 0 to slot 1
`timescale 1ns/1ps

module operand_resolve (
	input rename_pkg::dec_inst_t inst [rename_pkg::ISSUE_WIDTH],
	input rename_pkg::preg_t new_preg [rename_pkg::ISSUE_WIDTH],
	output rename_pkg::lreg_t rd_lreg [2*rename_pkg::ISSUE_WIDTH],
	input rename_pkg::preg_t rd_preg [2*rename_pkg::ISSUE_WIDTH],
	output rename_pkg::ren_inst_t renamed [rename_pkg::ISSUE_WIDTH]
);
	import rename_pkg::*;

	// Slot 0 produces a new name that slot 1 may need
	logic fwd_en;
	lreg_t src1_lreg [ISSUE_WIDTH];
	preg_t src0_name [ISSUE_WIDTH];
	preg_t src1_name [ISSUE_WIDTH];

	assign fwd_en = inst[0].valid && inst[0].writeback;

	// Map read ports, even index is source 0, odd is source 1
	always_comb begin
		for (int s = 0; s < ISSUE_WIDTH; s++) begin
			src1_lreg[s] = inst[s].src1.regv.name[LREG_W-1:0];
			rd_lreg[2*s] = inst[s].src0;
			rd_lreg[2*s+1] = src1_lreg[s];
		end
	end

	always_comb begin
		for (int s = 0; s < ISSUE_WIDTH; s++) begin
			src0_name[s] = rd_preg[2*s];
			src1_name[s] = rd_preg[2*s+1];
		end
		// Map still holds the old name for slot 0's dest
		if (fwd_en && inst[1].src0 == inst[0].dest) begin
			src0_name[1] = new_preg[0];
		end
		if (fwd_en && src1_lreg[1] == inst[0].dest) begin
			src1_name[1] = new_preg[0];
		end
	end

	// Assemble the renamed pair
	always_comb begin
		for (int s = 0; s < ISSUE_WIDTH; s++) begin
			renamed[s].valid = inst[s].valid;
			renamed[s].writeback = inst[s].writeback;
			renamed[s].src1_imm = inst[s].src1_imm;
			renamed[s].cmd = inst[s].cmd;
			renamed[s].dest = inst[s].dest;
			renamed[s].dest_preg = inst[s].writeback ? new_preg[s] : '0;
			renamed[s].src0 = src0_name[s];
			renamed[s].src1 = inst[s].src1;
			// Immediates pass untouched
			if (!inst[s].src1_imm) begin
				renamed[s].src1.regv.pad = '0;
				renamed[s].src1.regv.name = src1_name[s];
			end
		end
	end

endmodule

// ==== hw/rename_buffer.sv ====
// Output register for the renamed instruction pair, held while locked
`timescale 1ns/1ps

module rename_buffer (
	input logic iCLOCK,
	input logic inRESET,
	input logic restart,
	input logic lock,
	input rename_pkg::ren_inst_t renamed [rename_pkg::ISSUE_WIDTH],
	output rename_pkg::ren_inst_t held [rename_pkg::ISSUE_WIDTH]
);
	import rename_pkg::*;

	ren_inst_t buf_q [ISSUE_WIDTH];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int s = 0; s < ISSUE_WIDTH; s++) begin
				buf_q[s] <= '0;
			end
		end else if (restart) begin
			// Flush, the pair accepted this cycle is dropped too
			for (int s = 0; s < ISSUE_WIDTH; s++) begin
				buf_q[s] <= '0;
			end
		end else if (!lock) begin
			buf_q <= renamed;
		end
	end

	assign held = buf_q;

endmodule

// ==== hw/rename_top.sv ====
// Rename stage top level with lock, free-list requests and the rename pipeline
`timescale 1ns/1ps

module rename_top #(
	parameter int COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH_DEFAULT
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic restart,
	// Previous stage
	input rename_pkg::dec_inst_t prev_inst [rename_pkg::ISSUE_WIDTH],
	output logic prev_lock,
	// Free-list channels
	input rename_pkg::preg_t free_num_0,
	input rename_pkg::preg_t free_num_1,
	input logic free_empty_0,
	input logic free_empty_1,
	output logic free_rd_0,
	output logic free_rd_1,
	// Retirement
	input rename_pkg::map_wr_t commit [COMMIT_WIDTH],
	// Next stage
	output rename_pkg::ren_inst_t next_inst [rename_pkg::ISSUE_WIDTH],
	output logic [rename_pkg::ISSUE_WIDTH-1:0] stage_valid,
	input logic next_lock
);
	import rename_pkg::*;

	logic lock;
	logic [ISSUE_WIDTH-1:0] pop;
	preg_t free_num [ISSUE_WIDTH];
	map_wr_t alloc [ISSUE_WIDTH];
	lreg_t rd_lreg [2*ISSUE_WIDTH];
	preg_t rd_preg [2*ISSUE_WIDTH];
	ren_inst_t renamed [ISSUE_WIDTH];
	ren_inst_t held [ISSUE_WIDTH];

	// Stall on an empty free list or a blocked next stage
	assign lock = free_empty_0 || free_empty_1 || next_lock;
	assign prev_lock = lock;

	assign free_num[0] = free_num_0;
	assign free_num[1] = free_num_1;

	// One pop per writing instruction, same pop drives the map write
	always_comb begin
		for (int s = 0; s < ISSUE_WIDTH; s++) begin
			pop[s] = prev_inst[s].valid && prev_inst[s].writeback && !lock;
			alloc[s].valid = pop[s];
			alloc[s].lreg = prev_inst[s].dest;
			alloc[s].preg = free_num[s];
		end
	end

	assign free_rd_0 = pop[0];
	assign free_rd_1 = pop[1];

	map_table #(
		.COMMIT_WIDTH(COMMIT_WIDTH)
	) u_map_table (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.restart(restart),
		.alloc(alloc),
		.commit(commit),
		.rd_lreg(rd_lreg),
		.rd_preg(rd_preg)
	);

	operand_resolve u_operand_resolve (
		.inst(prev_inst),
		.new_preg(free_num),
		.rd_lreg(rd_lreg),
		.rd_preg(rd_preg),
		.renamed(renamed)
	);

	rename_buffer u_rename_buffer (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.restart(restart),
		.lock(lock),
		.renamed(renamed),
		.held(held)
	);

	// Valids go out only while the stage is not locked
	always_comb begin
		for (int s = 0; s < ISSUE_WIDTH; s++) begin
			next_inst[s] = held[s];
			next_inst[s].valid = held[s].valid && !lock;
			stage_valid[s] = held[s].valid;
		end
	end

endmodule

// ==== testbench/tb_checker.sv ====
// Checker that watches the rename stage outputs and compares them with expected values
`timescale 1ns/1ps

module tb_checker (
	input logic iCLOCK,
	input logic check_en,
	// DUT outputs under watch
	input rename_pkg::ren_inst_t next_inst [rename_pkg::ISSUE_WIDTH],
	input logic [rename_pkg::ISSUE_WIDTH-1:0] stage_valid,
	input logic prev_lock,
	input logic free_rd_0,
	input logic free_rd_1,
	// Expected values for the current cycle
	input rename_pkg::ren_inst_t exp_inst [rename_pkg::ISSUE_WIDTH],
	input logic [rename_pkg::ISSUE_WIDTH-1:0] exp_stage_valid,
	input logic exp_prev_lock,
	input logic [rename_pkg::ISSUE_WIDTH-1:0] exp_free_rd,
	output int error_count,
	output int check_count
);
	import rename_pkg::*;

	logic [ISSUE_WIDTH-1:0] free_rd;

	assign free_rd = {free_rd_1, free_rd_0};

	initial begin
		error_count = 0;
		check_count = 0;
	end

	// Compare one value and count a mismatch
	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("mismatch %s expected %h actual %h at %0t", name, expected, actual,
				$time);
		end
	endtask

	// Sample on the falling edge where outputs have settled
	always @(negedge iCLOCK) begin
		if (check_en) begin
			compare_value("prev_lock", 32'(exp_prev_lock), 32'(prev_lock));
			compare_value("stage_valid", 32'(exp_stage_valid), 32'(stage_valid));
			compare_value("free_rd", 32'(exp_free_rd), 32'(free_rd));
			for (int s = 0; s < ISSUE_WIDTH; s++) begin
				compare_value($sformatf("next_inst[%0d].valid", s),
					32'(exp_inst[s].valid), 32'(next_inst[s].valid));
				// Payload only means something while the slot is buffered
				if (exp_stage_valid[s]) begin
					compare_value($sformatf("next_inst[%0d].writeback", s),
						32'(exp_inst[s].writeback), 32'(next_inst[s].writeback));
					compare_value($sformatf("next_inst[%0d].src1_imm", s),
						32'(exp_inst[s].src1_imm), 32'(next_inst[s].src1_imm));
					compare_value($sformatf("next_inst[%0d].cmd", s),
						32'(exp_inst[s].cmd), 32'(next_inst[s].cmd));
					compare_value($sformatf("next_inst[%0d].dest", s),
						32'(exp_inst[s].dest), 32'(next_inst[s].dest));
					compare_value($sformatf("next_inst[%0d].dest_preg", s),
						32'(exp_inst[s].dest_preg), 32'(next_inst[s].dest_preg));
					compare_value($sformatf("next_inst[%0d].src0", s),
						32'(exp_inst[s].src0), 32'(next_inst[s].src0));
					compare_value($sformatf("next_inst[%0d].src1", s),
						exp_inst[s].src1.imm, next_inst[s].src1.imm);
				end
			end
		end
	end

endmodule

// ==== testbench/tb_rename.sv ====
// Testbench top for the rename stage with clock, reset, free-list models and file stimulus
`timescale 1ns/1ps

module tb_rename;
	import rename_pkg::*;

	localparam int COMMIT_WIDTH = 4;
	localparam int MAX_REC = 64;
	localparam int FL_DEPTH = 16;

	logic iCLOCK;
	logic inRESET;
	logic restart;
	logic next_lock;
	logic free_empty_0;
	logic free_empty_1;
	logic free_rd_0;
	logic free_rd_1;
	logic prev_lock;
	preg_t free_num_0;
	preg_t free_num_1;
	dec_inst_t prev_inst [ISSUE_WIDTH];
	map_wr_t commit [COMMIT_WIDTH];
	ren_inst_t next_inst [ISSUE_WIDTH];
	logic [ISSUE_WIDTH-1:0] stage_valid;

	// Expected values handed to the checker
	logic check_en;
	ren_inst_t exp_inst [ISSUE_WIDTH];
	logic [ISSUE_WIDTH-1:0] exp_stage_valid;
	logic exp_prev_lock;
	logic [ISSUE_WIDTH-1:0] exp_free_rd;
	int error_count;
	int check_count;

	// Pair the output buffer took most recently
	dec_inst_t acc_inst [ISSUE_WIDTH];

	// Records read from the data file
	dec_inst_t r_inst [MAX_REC][ISSUE_WIDTH];
	logic [3:0] r_ctrl [MAX_REC];
	map_wr_t r_commit [MAX_REC][COMMIT_WIDTH];
	ren_inst_t r_exp [MAX_REC][ISSUE_WIDTH];
	logic [ISSUE_WIDTH-1:0] r_sv [MAX_REC];
	int nrec;
	int cycle_limit;
	int cycle_count;
	int tb_errors;

	// Free-list models with 32 to 47 on channel 0 and 48 to 63 on channel 1
	preg_t fl0 [FL_DEPTH];
	preg_t fl1 [FL_DEPTH];
	int head0;
	int head1;

	rename_top #(
		.COMMIT_WIDTH(COMMIT_WIDTH)
	) dut (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.restart(restart),
		.prev_inst(prev_inst),
		.prev_lock(prev_lock),
		.free_num_0(free_num_0),
		.free_num_1(free_num_1),
		.free_empty_0(free_empty_0),
		.free_empty_1(free_empty_1),
		.free_rd_0(free_rd_0),
		.free_rd_1(free_rd_1),
		.commit(commit),
		.next_inst(next_inst),
		.stage_valid(stage_valid),
		.next_lock(next_lock)
	);

	tb_checker u_checker (
		.iCLOCK(iCLOCK),
		.check_en(check_en),
		.next_inst(next_inst),
		.stage_valid(stage_valid),
		.prev_lock(prev_lock),
		.free_rd_0(free_rd_0),
		.free_rd_1(free_rd_1),
		.exp_inst(exp_inst),
		.exp_stage_valid(exp_stage_valid),
		.exp_prev_lock(exp_prev_lock),
		.exp_free_rd(exp_free_rd),
		.error_count(error_count),
		.check_count(check_count)
	);

	always #5 iCLOCK = ~iCLOCK;

	assign free_num_0 = (head0 < FL_DEPTH) ? fl0[head0] : '0;
	assign free_num_1 = (head1 < FL_DEPTH) ? fl1[head1] : '0;

	// Pop on the edge where the read request is high
	always @(posedge iCLOCK) begin
		if (free_rd_0) begin
			if (head0 >= FL_DEPTH) begin
				tb_errors++;
				$display("Free list 0 was read after it ran out of registers");
			end
			head0 <= head0 + 1;
		end
		if (free_rd_1) begin
			if (head1 >= FL_DEPTH) begin
				tb_errors++;
				$display("Free list 1 was read after it ran out of registers");
			end
			head1 <= head1 + 1;
		end
	end

	always @(posedge iCLOCK) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			$display("Errors found");
			$finish;
		end
	end

	// Fetch the next non-comment line and clear ok at end of file
	task automatic read_data_line(input int fd, output string line, output int ok);
		int got;
		ok = 0;
		got = $fgets(line, fd);
		while (got != 0 && !ok) begin
			if (line.len() > 1 && line.getc(0) != 8'h23) begin
				ok = 1;
			end else begin
				got = $fgets(line, fd);
			end
		end
	endtask

	task automatic load_records();
		int fd;
		int ok;
		int n;
		string la;
		string lb;
		logic [31:0] a [18];
		logic [31:0] b [18];
		fd = $fopen("testbench/rename_testdata.txt", "r");
		if (fd == 0) begin
			tb_errors++;
			$display("Could not open the stimulus file");
		end else begin
			read_data_line(fd, la, ok);
			while (ok && nrec < MAX_REC) begin
				read_data_line(fd, lb, ok);
				if (!ok) begin
					tb_errors++;
					$display("Stimulus file ends in the middle of a record");
				end else begin
					n = $sscanf(la, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7], a[8],
						a[9], a[10], a[11], a[12], a[13], a[14], a[15], a[16], a[17]);
					n += $sscanf(lb, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7], b[8],
						b[9], b[10], b[11], b[12], b[13], b[14], b[15], b[16], b[17]);
					if (n != 36) begin
						tb_errors++;
						$display("Record %0d in the stimulus file is malformed", nrec);
					end
					for (int s = 0; s < ISSUE_WIDTH; s++) begin
						r_inst[nrec][s] = {a[7*s][0], a[7*s+1][0], a[7*s+2][0],
							a[7*s+3][4:0], a[7*s+4][4:0], a[7*s+5][4:0], a[7*s+6]};
						r_exp[nrec][s] = '0;
						r_exp[nrec][s].valid = b[9+4*s][0];
						r_exp[nrec][s].dest_preg = b[10+4*s][5:0];
						r_exp[nrec][s].src0 = b[11+4*s][5:0];
						r_exp[nrec][s].src1.imm = b[12+4*s];
					end
					r_ctrl[nrec] = {a[14][0], a[15][0], a[16][0], a[17][0]};
					for (int c = 0; c < COMMIT_WIDTH; c++) begin
						r_commit[nrec][c] = {b[0][c], b[1+2*c][4:0], b[2+2*c][5:0]};
					end
					r_sv[nrec] = b[17][1:0];
					nrec++;
					read_data_line(fd, la, ok);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_record(input int i);
		logic lock;
		restart = r_ctrl[i][3];
		next_lock = r_ctrl[i][2];
		free_empty_0 = r_ctrl[i][1];
		free_empty_1 = r_ctrl[i][0];
		commit = r_commit[i];
		prev_inst = r_inst[i];
		// Stall whenever a free list is empty or the next stage holds
		lock = r_ctrl[i][2] | r_ctrl[i][1] | r_ctrl[i][0];
		exp_prev_lock = lock;
		for (int s = 0; s < ISSUE_WIDTH; s++) begin
			exp_free_rd[s] = r_inst[i][s].valid & r_inst[i][s].writeback & ~lock;
		end
		exp_inst = r_exp[i];
		exp_stage_valid = r_sv[i];
		// Untranslated fields come unchanged from the buffered pair
		for (int s = 0; s < ISSUE_WIDTH; s++) begin
			exp_inst[s].writeback = acc_inst[s].writeback;
			exp_inst[s].src1_imm = acc_inst[s].src1_imm;
			exp_inst[s].cmd = acc_inst[s].cmd;
			exp_inst[s].dest = acc_inst[s].dest;
		end
		// Restart empties the buffer and lock keeps the old pair
		if (r_ctrl[i][3]) begin
			for (int s = 0; s < ISSUE_WIDTH; s++) begin
				acc_inst[s] = '0;
			end
		end else if (!lock) begin
			acc_inst = r_inst[i];
		end
	endtask

	initial begin
		iCLOCK = 0;
		inRESET = 0;
		restart = 0;
		next_lock = 0;
		free_empty_0 = 0;
		free_empty_1 = 0;
		check_en = 0;
		exp_prev_lock = 0;
		exp_free_rd = '0;
		exp_stage_valid = '0;
		nrec = 0;
		cycle_count = 0;
		cycle_limit = 1000;
		tb_errors = 0;
		head0 = 0;
		head1 = 0;
		for (int s = 0; s < ISSUE_WIDTH; s++) begin
			prev_inst[s] = '0;
			exp_inst[s] = '0;
			acc_inst[s] = '0;
		end
		for (int c = 0; c < COMMIT_WIDTH; c++) begin
			commit[c] = '0;
		end
		for (int i = 0; i < FL_DEPTH; i++) begin
			fl0[i] = preg_t'(32 + i);
			fl1[i] = preg_t'(48 + i);
		end
		load_records();
		cycle_limit = 2 * nrec + 50;
		if (nrec == 0) begin
			tb_errors++;
			$display("No stimulus records were loaded");
		end
		repeat (16) @(posedge iCLOCK);
		#1;
		inRESET = 1;
		for (int i = 0; i < nrec; i++) begin
			@(posedge iCLOCK);
			#1;
			drive_record(i);
			check_en = 1;
		end
		@(posedge iCLOCK);
		#1;
		check_en = 0;
		@(posedge iCLOCK);
		$display("Checks %0d, checker errors %0d, testbench errors %0d",
			check_count, error_count, tb_errors);
		if (error_count == 0 && tb_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== testbench/rename_testdata.txt ====
# Two lines per cycle. A: per slot v wb imm cmd dest src0 src1, then restart next_lock empty0 empty1
# B: commit mask, four lreg preg pairs, then per slot expected v dest_preg src0 src1, stage_valid
# Expected columns are the outputs seen while line A is applied
# Reset state, identity lookups
1 0 0 01 00 03 07 1 0 0 02 00 1f 0a 0 0 0 0
0 00 00 00 00 00 00 00 00 0 00 00 0 0 00 00 0 0
# Two writers, slot 1 has an immediate
1 1 0 03 05 01 02 1 1 1 04 06 04 dead0042 0 0 0 0
0 00 00 00 00 00 00 00 00 1 00 03 7 1 00 1f a 3
# Read the new names
1 0 0 05 00 05 06 1 0 0 06 00 06 05 0 0 0 0
0 00 00 00 00 00 00 00 00 1 20 01 2 1 30 04 dead0042 3
# Slot 1 reads slot 0 dest
1 1 0 07 05 05 06 1 1 0 08 07 05 05 0 0 0 0
0 00 00 00 00 00 00 00 00 1 00 20 30 1 00 30 20 3
# Next stage lock
1 1 0 09 08 07 05 1 0 0 0a 00 08 01 0 1 0 0
0 00 00 00 00 00 00 00 00 0 21 20 30 0 31 21 21 3
# Free list 0 empty
1 1 0 09 08 07 05 1 0 0 0a 00 08 01 0 0 1 0
0 00 00 00 00 00 00 00 00 0 21 20 30 0 31 21 21 3
# Lock released
1 1 0 09 08 07 05 1 0 0 0a 00 08 01 0 0 0 0
0 00 00 00 00 00 00 00 00 1 21 20 30 1 31 21 21 3
# Commits, port 2 wins on lreg 5, port 3 masked
0 0 0 00 00 00 0 0 0 0 00 00 00 0 0 0 0 0
7 05 20 06 30 05 21 07 31 1 22 31 21 1 00 22 01 3
# Restart with a same-cycle commit, input dropped
1 0 0 0b 00 08 05 0 0 0 00 00 00 0 1 0 0 0
1 08 22 00 00 00 00 00 00 0 00 00 0 0 00 00 0 0
# Read restored names
1 0 0 0c 00 07 05 1 0 0 0d 00 06 08 0 0 0 0
0 00 00 00 00 00 00 00 00 0 00 00 0 0 00 00 0 0
0 0 0 00 00 00 0 0 0 0 00 00 00 0 0 0 0 0
0 00 00 00 00 00 00 00 00 1 00 07 21 1 00 30 22 3
0 0 0 00 00 00 0 0 0 0 00 00 00 0 0 0 0 0
0 00 00 00 00 00 00 00 00 0 00 00 0 0 00 00 0 0

// ==== all.f ====
hw/rename_pkg.sv
hw/map_table.sv
hw/operand_resolve.sv
hw/rename_buffer.sv
hw/rename_top.sv
testbench/tb_checker.sv
testbench/tb_rename.sv

// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - hw/rename_pkg.sv
  - hw/map_table.sv
  - hw/operand_resolve.sv
  - hw/rename_buffer.sv
  - hw/rename_top.sv
  - target: test
    files:
      - testbench/tb_checker.sv
      - testbench/tb_rename.sv
